// ==== hw/swarm_pkg.sv ====
`default_nettype none

package swarm_pkg;

   localparam int LOG_TSB_SIZE      = 3;
   localparam int TSB_SIZE          = 2 ** LOG_TSB_SIZE;
   localparam int MAX_TILES         = 8;
   localparam int ONLY_UNTIED_LEVEL = TSB_SIZE - 3; // Above this, tied tasks are held back.

   typedef logic [31:0]             ts_t;
   typedef logic [31:0]             hint_t;
   typedef logic [2:0]              tile_id_t;
   typedef logic [LOG_TSB_SIZE-1:0] tsb_entry_id_t;
   typedef logic [7:0]              epoch_t;
   typedef logic [5:0]              tq_slot_t;
   typedef logic [3:0]              cq_slice_slot_t;
   typedef logic [1:0]              child_id_t;
   typedef logic [3:0]              n_tiles_t;
   typedef logic [7:0]              reg_addr_t;
   typedef logic [31:0]             reg_data_t;

   typedef struct packed {
      ts_t         ts;
      hint_t       hint;
      logic [31:0] args;
   } task_t;

   typedef struct packed {
      logic      valid;
      reg_addr_t addr;
      reg_data_t data;
   } reg_wr_t;

   typedef struct packed {
      logic      valid;
      reg_addr_t addr;
   } reg_rd_t;

   localparam n_tiles_t  N_TILES         = 4;     // Tile count out of reset.
   localparam reg_addr_t TSB_LOG_N_TILES = 8'h10;
   localparam reg_addr_t TSB_ENTRY_VALID = 8'h14;

endpackage

`default_nettype wire

// ==== hw/tile_hash.sv ====
`default_nettype none

module tile_hash (
   input  swarm_pkg::hint_t    hint,
   input  swarm_pkg::n_tiles_t n_tiles,
   output swarm_pkg::tile_id_t tile
);
   import swarm_pkg::*;

   n_tiles_t mask;

   always_comb begin
      mask = n_tiles - 1'b1;
      if (n_tiles <= n_tiles_t'(1)) begin
         tile = '0;
      end else if ((n_tiles & mask) == '0) begin
         tile = hint[6:4] & mask[2:0]; // Power of two, plain bit select.
      end else begin
         tile = tile_id_t'(hint[30:4] % n_tiles);
      end
   end

   // Destination must name an existing tile.
   always_comb begin
      if (n_tiles != '0) begin
         assert (tile < n_tiles)
            else $error("tile_hash: tile %0d not below count %0d", tile, n_tiles);
      end
   end

endmodule

`default_nettype wire

// ==== hw/tsb_entry_table.sv ====
`default_nettype none

module tsb_entry_table (
   input  logic                             clk,
   input  logic                             rstn,
   input  logic                             alloc,
   input  swarm_pkg::task_t                 alloc_task,
   input  swarm_pkg::tile_id_t              alloc_tile,
   input  logic                             alloc_tied,
   input  swarm_pkg::cq_slice_slot_t        alloc_cq_slot,
   input  swarm_pkg::child_id_t             alloc_child_id,
   input  logic                             set_tied,
   input  swarm_pkg::tsb_entry_id_t         set_tied_id,
   input  logic                             set_tied_val,
   input  logic                             release_a,
   input  swarm_pkg::tsb_entry_id_t         release_a_id,
   input  logic                             release_b,
   input  swarm_pkg::tsb_entry_id_t         release_b_id,
   input  swarm_pkg::tsb_entry_id_t         rd_id,
   input  swarm_pkg::tsb_entry_id_t         resp_id,
   input  swarm_pkg::tsb_entry_id_t         scan_id,
   output swarm_pkg::tsb_entry_id_t         free_id,
   output logic                             has_free,
   output swarm_pkg::task_t                 rd_task,
   output swarm_pkg::tile_id_t              rd_tile,
   output logic                             rd_tied,
   output swarm_pkg::cq_slice_slot_t        rd_cq_slot,
   output swarm_pkg::child_id_t             rd_child_id,
   output logic                             resp_tied,
   output swarm_pkg::tile_id_t              resp_tile,
   output swarm_pkg::cq_slice_slot_t        resp_cq_slot,
   output swarm_pkg::child_id_t             resp_child_id,
   output swarm_pkg::ts_t                   scan_ts,
   output logic [swarm_pkg::TSB_SIZE-1:0]   entry_valid,
   output logic                             only_untied
);
   import swarm_pkg::*;

   logic [TSB_SIZE-1:0]   valid_q;
   logic [LOG_TSB_SIZE:0] count_q;

   task_t          entry_task     [TSB_SIZE];
   tile_id_t       entry_tile     [TSB_SIZE];
   logic           entry_tied     [TSB_SIZE];
   cq_slice_slot_t entry_cq_slot  [TSB_SIZE];
   child_id_t      entry_child_id [TSB_SIZE];

   // Lowest free index wins.
   always_comb begin
      free_id  = '0;
      has_free = 1'b0;
      for (int i = TSB_SIZE - 1; i >= 0; i--) begin
         if (!valid_q[i]) begin
            free_id  = tsb_entry_id_t'(i);
            has_free = 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         valid_q <= '0;
         count_q <= '0;
      end else begin
         for (int i = 0; i < TSB_SIZE; i++) begin
            if (alloc && free_id == tsb_entry_id_t'(i)) begin
               valid_q[i] <= 1'b1;
            end else if ((release_a && release_a_id == tsb_entry_id_t'(i)) ||
                         (release_b && release_b_id == tsb_entry_id_t'(i))) begin
               valid_q[i] <= 1'b0;
            end
         end
         count_q <= count_q + (LOG_TSB_SIZE + 1)'(alloc)
                    - (LOG_TSB_SIZE + 1)'(release_a) - (LOG_TSB_SIZE + 1)'(release_b);
      end
   end

   always_ff @(posedge clk) begin
      if (alloc) begin
         entry_task[free_id]     <= alloc_task;
         entry_tile[free_id]     <= alloc_tile;
         entry_tied[free_id]     <= alloc_tied;
         entry_cq_slot[free_id]  <= alloc_cq_slot;
         entry_child_id[free_id] <= alloc_child_id;
      end
      if (set_tied) begin
         entry_tied[set_tied_id] <= set_tied_val; // Retry may change tied state.
      end
   end

   assign rd_task       = entry_task[rd_id];
   assign rd_tile       = entry_tile[rd_id];
   assign rd_tied       = entry_tied[rd_id];
   assign rd_cq_slot    = entry_cq_slot[rd_id];
   assign rd_child_id   = entry_child_id[rd_id];
   assign resp_tied     = entry_tied[resp_id];
   assign resp_tile     = entry_tile[resp_id];
   assign resp_cq_slot  = entry_cq_slot[resp_id];
   assign resp_child_id = entry_child_id[resp_id];
   assign scan_ts       = entry_task[scan_id].ts;
   assign entry_valid   = valid_q;
   assign only_untied   = count_q > ONLY_UNTIED_LEVEL;

   assert property (@(posedge clk) disable iff (!rstn) alloc |-> has_free);
   assert property (@(posedge clk) disable iff (!rstn)
      (release_a |-> valid_q[release_a_id]) and (release_b |-> valid_q[release_b_id]));
   assert property (@(posedge clk) disable iff (!rstn) count_q <= TSB_SIZE);

endmodule

`default_nettype wire

// ==== hw/tsb_lvt_scan.sv ====
`default_nettype none

module tsb_lvt_scan (
   input  logic                           clk,
   input  logic                           rstn,
   input  logic [swarm_pkg::TSB_SIZE-1:0] entry_valid,
   input  swarm_pkg::ts_t                 scan_ts,
   output swarm_pkg::tsb_entry_id_t       scan_id,
   output swarm_pkg::ts_t                 lvt
);
   import swarm_pkg::*;

   ts_t min_q;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         scan_id <= '0;
         min_q   <= '0; // Keeps lvt at zero through the first pass.
         lvt     <= '0;
      end else begin
         scan_id <= scan_id + 1'b1;
         if (scan_id == '0) begin
            lvt   <= min_q;
            min_q <= entry_valid[0] ? scan_ts : '1;
         end else if (entry_valid[scan_id] && scan_ts < min_q) begin
            min_q <= scan_ts;
         end
      end
   end

endmodule

`default_nettype wire

// ==== hw/tsb.sv ====
`default_nettype none

module tsb (
   input  logic                           clk,
   input  logic                           rstn,
   input  logic                           s_wvalid,
   output logic                           s_wready,
   input  swarm_pkg::task_t               s_wdata,
   input  logic                           s_tied,
   input  swarm_pkg::cq_slice_slot_t      s_cq_slot,
   input  swarm_pkg::child_id_t           s_child_id,
   output logic                           s_only_untied,
   input  logic                           retry_valid,
   output logic                           retry_ready,
   input  swarm_pkg::tsb_entry_id_t       retry_tsb_id,
   input  logic                           retry_abort,
   input  logic                           retry_tied,
   output logic                           task_enq_valid,
   input  logic                           task_enq_ready,
   output swarm_pkg::task_t               task_enq_data,
   output logic                           task_enq_tied,
   output swarm_pkg::tile_id_t            task_enq_dest_tile,
   output swarm_pkg::tsb_entry_id_t       task_enq_tsb_id,
   input  logic                           task_resp_valid,
   output logic                           task_resp_ready,
   input  logic                           task_resp_ack,
   input  swarm_pkg::tsb_entry_id_t       task_resp_tsb_id,
   input  swarm_pkg::epoch_t              task_resp_epoch,
   input  swarm_pkg::tq_slot_t            task_resp_tq_slot,
   output logic                           m_resp_valid,
   input  logic                           m_resp_ready,
   output logic                           m_resp_ack,
   output swarm_pkg::tsb_entry_id_t       m_tsb_slot,
   output swarm_pkg::epoch_t              m_epoch,
   output swarm_pkg::tq_slot_t            m_tq_slot,
   output swarm_pkg::tile_id_t            m_tile_id,
   output swarm_pkg::cq_slice_slot_t      m_cq_slot,
   output swarm_pkg::child_id_t           m_child_id,
   input  swarm_pkg::n_tiles_t            n_tiles,
   output logic [swarm_pkg::TSB_SIZE-1:0] entry_valid,
   output swarm_pkg::ts_t                 lvt,
   output logic                           empty
);
   import swarm_pkg::*;

   tile_id_t       dest_tile;
   tsb_entry_id_t  free_id;
   tsb_entry_id_t  scan_id;
   logic           has_free;
   task_t          rd_task;
   tile_id_t       rd_tile;
   logic           resp_tied;
   tile_id_t       resp_tile;
   cq_slice_slot_t resp_cq_slot;
   child_id_t      resp_child_id;
   ts_t            scan_ts;
   logic           enq_free;
   logic           new_acc;
   logic           retry_acc;
   logic           resend;
   logic           resp_acc;

   assign enq_free        = !task_enq_valid || task_enq_ready;
   assign s_wready        = enq_free && has_free;
   assign retry_ready     = enq_free && !(s_wvalid && has_free); // New task has priority.
   assign new_acc         = s_wvalid && s_wready;
   assign retry_acc       = retry_valid && retry_ready;
   assign resend          = retry_acc && !retry_abort;
   assign task_resp_ready = !m_resp_valid;
   assign resp_acc        = task_resp_valid && task_resp_ready;
   assign empty           = entry_valid == '0;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         task_enq_valid <= 1'b0;
      end else if (new_acc || resend) begin
         task_enq_valid <= 1'b1;
      end else if (task_enq_ready) begin
         task_enq_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (new_acc) begin
         task_enq_data      <= s_wdata;
         task_enq_tied      <= s_tied;
         task_enq_dest_tile <= dest_tile;
         task_enq_tsb_id    <= free_id;
      end else if (resend) begin
         task_enq_data      <= rd_task; // Stored copy goes out again.
         task_enq_tied      <= retry_tied;
         task_enq_dest_tile <= rd_tile;
         task_enq_tsb_id    <= retry_tsb_id;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         m_resp_valid <= 1'b0;
      end else if (resp_acc && resp_tied) begin
         m_resp_valid <= 1'b1;
      end else if (m_resp_ready) begin
         m_resp_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (resp_acc && resp_tied) begin
         m_resp_ack <= task_resp_ack;
         m_tsb_slot <= task_resp_tsb_id;
         m_epoch    <= task_resp_epoch;
         m_tq_slot  <= task_resp_tq_slot;
         m_tile_id  <= resp_tile;
         m_cq_slot  <= resp_cq_slot;
         m_child_id <= resp_child_id;
      end
   end

   tile_hash hash_i (
      .hint    (s_wdata.hint),
      .n_tiles (n_tiles),
      .tile    (dest_tile)
   );

   tsb_entry_table table_i (
      .clk            (clk),
      .rstn           (rstn),
      .alloc          (new_acc),
      .alloc_task     (s_wdata),
      .alloc_tile     (dest_tile),
      .alloc_tied     (s_tied),
      .alloc_cq_slot  (s_cq_slot),
      .alloc_child_id (s_child_id),
      .set_tied       (resend),
      .set_tied_id    (retry_tsb_id),
      .set_tied_val   (retry_tied),
      .release_a      (resp_acc && task_resp_ack),
      .release_a_id   (task_resp_tsb_id),
      .release_b      (retry_acc && retry_abort),
      .release_b_id   (retry_tsb_id),
      .rd_id          (retry_tsb_id),
      .resp_id        (task_resp_tsb_id),
      .scan_id        (scan_id),
      .free_id        (free_id),
      .has_free       (has_free),
      .rd_task        (rd_task),
      .rd_tile        (rd_tile),
      .rd_tied        (),
      .rd_cq_slot     (),
      .rd_child_id    (),
      .resp_tied      (resp_tied),
      .resp_tile      (resp_tile),
      .resp_cq_slot   (resp_cq_slot),
      .resp_child_id  (resp_child_id),
      .scan_ts        (scan_ts),
      .entry_valid    (entry_valid),
      .only_untied    (s_only_untied)
   );

   tsb_lvt_scan scan_i (
      .clk         (clk),
      .rstn        (rstn),
      .entry_valid (entry_valid),
      .scan_ts     (scan_ts),
      .scan_id     (scan_id),
      .lvt         (lvt)
   );

   // Retries and responses name buffered entries.
   assert property (@(posedge clk) disable iff (!rstn)
      retry_acc |-> entry_valid[retry_tsb_id]);
   assert property (@(posedge clk) disable iff (!rstn)
      resp_acc |-> entry_valid[task_resp_tsb_id]);

endmodule

`default_nettype wire

// ==== hw/tsb_regs.sv ====
`default_nettype none

module tsb_regs (
   input  logic                           clk,
   input  logic                           rstn,
   input  swarm_pkg::reg_wr_t             reg_wr,
   input  swarm_pkg::reg_rd_t             reg_rd,
   input  logic [swarm_pkg::TSB_SIZE-1:0] entry_valid,
   output swarm_pkg::n_tiles_t            n_tiles,
   output logic                           reg_rvalid,
   output swarm_pkg::reg_data_t           reg_rdata
);
   import swarm_pkg::*;

   logic wr_n_tiles;

   assign wr_n_tiles = reg_wr.valid && reg_wr.addr == TSB_LOG_N_TILES;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         n_tiles    <= N_TILES;
         reg_rvalid <= 1'b0;
      end else begin
         reg_rvalid <= reg_rd.valid;
         if (wr_n_tiles) begin
            n_tiles <= n_tiles_t'(reg_wr.data);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reg_rd.valid) begin
         case (reg_rd.addr)
            TSB_LOG_N_TILES: reg_rdata <= reg_data_t'(n_tiles);
            TSB_ENTRY_VALID: reg_rdata <= reg_data_t'(entry_valid);
            default:         reg_rdata <= '0; // Unmapped reads as zero.
         endcase
      end
   end

   assert property (@(posedge clk) disable iff (!rstn)
      wr_n_tiles |-> reg_wr.data >= 1 && reg_wr.data <= MAX_TILES);

endmodule

`default_nettype wire

// ==== hw/tsb_subsys.sv ====
`default_nettype none

module tsb_subsys (
   input  logic                      clk,
   input  logic                      rstn,
   input  logic                      s_wvalid,
   output logic                      s_wready,
   input  swarm_pkg::task_t          s_wdata,
   input  logic                      s_tied,
   input  swarm_pkg::cq_slice_slot_t s_cq_slot,
   input  swarm_pkg::child_id_t      s_child_id,
   output logic                      s_only_untied,
   input  logic                      retry_valid,
   output logic                      retry_ready,
   input  swarm_pkg::tsb_entry_id_t  retry_tsb_id,
   input  logic                      retry_abort,
   input  logic                      retry_tied,
   output logic                      task_enq_valid,
   input  logic                      task_enq_ready,
   output swarm_pkg::task_t          task_enq_data,
   output logic                      task_enq_tied,
   output swarm_pkg::tile_id_t       task_enq_dest_tile,
   output swarm_pkg::tsb_entry_id_t  task_enq_tsb_id,
   input  logic                      task_resp_valid,
   output logic                      task_resp_ready,
   input  logic                      task_resp_ack,
   input  swarm_pkg::tsb_entry_id_t  task_resp_tsb_id,
   input  swarm_pkg::epoch_t         task_resp_epoch,
   input  swarm_pkg::tq_slot_t       task_resp_tq_slot,
   output logic                      m_resp_valid,
   input  logic                      m_resp_ready,
   output logic                      m_resp_ack,
   output swarm_pkg::tsb_entry_id_t  m_tsb_slot,
   output swarm_pkg::epoch_t         m_epoch,
   output swarm_pkg::tq_slot_t       m_tq_slot,
   output swarm_pkg::tile_id_t       m_tile_id,
   output swarm_pkg::cq_slice_slot_t m_cq_slot,
   output swarm_pkg::child_id_t      m_child_id,
   input  swarm_pkg::reg_wr_t        reg_wr,
   input  swarm_pkg::reg_rd_t        reg_rd,
   output logic                      reg_rvalid,
   output swarm_pkg::reg_data_t      reg_rdata,
   output swarm_pkg::ts_t            lvt,
   output logic                      empty
);
   import swarm_pkg::*;

   n_tiles_t            n_tiles;     // Set by software.
   logic [TSB_SIZE-1:0] entry_valid;

   tsb tsb_i (.*);

   tsb_regs regs_i (.*);

endmodule

`default_nettype wire

// ==== testbench/tb_tsb_subsys.sv ====
`default_nettype none

module tb_tsb_subsys;
   import swarm_pkg::*;

   localparam int HS_LIMIT = 20; // Cycles allowed for one handshake.
   localparam int WATCHDOG_CYCLES = 8 + 240 + 50 + 20 + 60 + 80 + 40 + 200;

   logic clk;
   logic rstn;
   logic s_wvalid;
   logic s_wready;
   task_t s_wdata;
   logic s_tied;
   cq_slice_slot_t s_cq_slot;
   child_id_t s_child_id;
   logic s_only_untied;
   logic retry_valid;
   logic retry_ready;
   tsb_entry_id_t retry_tsb_id;
   logic retry_abort;
   logic retry_tied;
   logic task_enq_valid;
   logic task_enq_ready;
   task_t task_enq_data;
   logic task_enq_tied;
   tile_id_t task_enq_dest_tile;
   tsb_entry_id_t task_enq_tsb_id;
   logic task_resp_valid;
   logic task_resp_ready;
   logic task_resp_ack;
   tsb_entry_id_t task_resp_tsb_id;
   epoch_t task_resp_epoch;
   tq_slot_t task_resp_tq_slot;
   logic m_resp_valid;
   logic m_resp_ready;
   logic m_resp_ack;
   tsb_entry_id_t m_tsb_slot;
   epoch_t m_epoch;
   tq_slot_t m_tq_slot;
   tile_id_t m_tile_id;
   cq_slice_slot_t m_cq_slot;
   child_id_t m_child_id;
   reg_wr_t reg_wr;
   reg_rd_t reg_rd;
   logic reg_rvalid;
   reg_data_t reg_rdata;
   ts_t lvt;
   logic empty;

   int seed = 29241;
   int checks_run = 0;
   int errors = 0;
   int n_tiles_model = N_TILES;

   // Scoreboard of buffered tasks.
   logic mvalid [TSB_SIZE];
   task_t mtask [TSB_SIZE];
   tile_id_t mtile [TSB_SIZE];
   logic mtied [TSB_SIZE];
   cq_slice_slot_t mcq [TSB_SIZE];
   child_id_t mchild [TSB_SIZE];

   tsb_subsys dut_i (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
      $display("Test failed");
      $finish;
   end

   task automatic check(input string name, input logic [95:0] got, input logic [95:0] exp);
      checks_run++;
      assert (got === exp) else begin
         errors++;
         $display("ERROR at %0t: %s is %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   task automatic handshake_lost(input string what);
      errors++;
      $display("At %0t the %s handshake never completed", $time, what);
   endtask

   function automatic tile_id_t expected_tile(input hint_t hint, input int n);
      int bits;
      if (n <= 1) return '0;
      if ((n & (n - 1)) == 0) begin
         bits = $clog2(n);
         return tile_id_t'((hint >> 4) & ((1 << bits) - 1)); // Low hint bits from bit 4.
      end
      return tile_id_t'(hint[30:4] % n);
   endfunction

   function automatic int lowest_free();
      for (int i = 0; i < TSB_SIZE; i++) begin
         if (!mvalid[i]) return i;
      end
      return -1;
   endfunction

   function automatic int occupancy();
      int n;
      n = 0;
      for (int i = 0; i < TSB_SIZE; i++) n += int'(mvalid[i]);
      return n;
   endfunction

   function automatic logic [TSB_SIZE-1:0] valid_bits();
      logic [TSB_SIZE-1:0] v;
      for (int i = 0; i < TSB_SIZE; i++) v[i] = mvalid[i];
      return v;
   endfunction

   function automatic ts_t min_ts();
      ts_t m;
      m = '1;
      for (int i = 0; i < TSB_SIZE; i++) begin
         if (mvalid[i] && mtask[i].ts < m) m = mtask[i].ts;
      end
      return m;
   endfunction

   task automatic check_enq(input task_t t, input logic tied, input tile_id_t tile,
                            input tsb_entry_id_t id);
      check("task_enq_valid", task_enq_valid, 1'b1);
      check("task_enq_data", task_enq_data, t);
      check("task_enq_tied", task_enq_tied, tied);
      check("task_enq_dest_tile", task_enq_dest_tile, tile);
      check("task_enq_tsb_id", task_enq_tsb_id, id);
   endtask

   task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
      @(posedge clk);
      reg_wr <= '{1'b1, addr, data};
      @(posedge clk);
      reg_wr <= '0;
      if (addr == TSB_LOG_N_TILES) n_tiles_model = int'(data);
   endtask

   task automatic reg_read_check(input reg_addr_t addr, input reg_data_t exp);
      @(posedge clk);
      reg_rd <= '{1'b1, addr};
      @(posedge clk);
      reg_rd <= '0;
      @(negedge clk);
      check("reg_rvalid", reg_rvalid, 1'b1);
      check("reg_rdata", reg_rdata, exp);
      @(negedge clk);
      check("reg_rvalid", reg_rvalid, 1'b0); // One cycle per read.
   endtask

   task automatic send_task(input logic tied, output tsb_entry_id_t id);
      task_t t;
      cq_slice_slot_t cq;
      child_id_t ch;
      int slot;
      int n;
      t.ts = $random(seed);
      t.hint = $random(seed);
      t.args = $random(seed);
      cq = cq_slice_slot_t'($random(seed));
      ch = child_id_t'($random(seed));
      slot = lowest_free();
      @(posedge clk);
      s_wvalid <= 1'b1;
      s_wdata <= t;
      s_tied <= tied;
      s_cq_slot <= cq;
      s_child_id <= ch;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!s_wready && n < HS_LIMIT);
      assert (s_wready) else handshake_lost("new task");
      @(posedge clk);
      s_wvalid <= 1'b0;
      id = tsb_entry_id_t'(slot);
      if (slot >= 0) begin
         mvalid[slot] = 1'b1;
         mtask[slot] = t;
         mtile[slot] = expected_tile(t.hint, n_tiles_model);
         mtied[slot] = tied;
         mcq[slot] = cq;
         mchild[slot] = ch;
      end
      @(negedge clk);
      check_enq(t, tied, expected_tile(t.hint, n_tiles_model), id);
   endtask

   task automatic retry(input tsb_entry_id_t id, input logic abort, input logic tied);
      int n;
      @(posedge clk);
      retry_valid <= 1'b1;
      retry_tsb_id <= id;
      retry_abort <= abort;
      retry_tied <= tied;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!retry_ready && n < HS_LIMIT);
      assert (retry_ready) else handshake_lost("retry");
      @(posedge clk);
      retry_valid <= 1'b0;
      if (abort) mvalid[id] = 1'b0;
      else mtied[id] = tied;
      @(negedge clk);
      if (abort) check("task_enq_valid", task_enq_valid, 1'b0);
      else check_enq(mtask[id], tied, mtile[id], id);
   endtask

   task automatic respond(input tsb_entry_id_t id, input logic ack);
      epoch_t ep;
      tq_slot_t tq;
      logic fwd;
      int n;
      ep = epoch_t'($random(seed));
      tq = tq_slot_t'($random(seed));
      fwd = mtied[id]; // Only tied entries report back.
      @(posedge clk);
      task_resp_valid <= 1'b1;
      task_resp_ack <= ack;
      task_resp_tsb_id <= id;
      task_resp_epoch <= ep;
      task_resp_tq_slot <= tq;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!task_resp_ready && n < HS_LIMIT);
      assert (task_resp_ready) else handshake_lost("task response");
      @(posedge clk);
      task_resp_valid <= 1'b0;
      if (ack) mvalid[id] = 1'b0;
      @(negedge clk);
      check("m_resp_valid", m_resp_valid, fwd);
      if (fwd) begin
         check("m_resp_ack", m_resp_ack, ack);
         check("m_tsb_slot", m_tsb_slot, id);
         check("m_epoch", m_epoch, ep);
         check("m_tq_slot", m_tq_slot, tq);
         check("m_tile_id", m_tile_id, mtile[id]);
         check("m_cq_slot", m_cq_slot, mcq[id]);
         check("m_child_id", m_child_id, mchild[id]);
      end
   endtask

   task automatic ack_all();
      for (int i = 0; i < TSB_SIZE; i++) begin
         if (mvalid[i]) respond(tsb_entry_id_t'(i), 1'b1);
      end
   endtask

   task automatic test_hash_and_regs();
      int counts [6] = '{1, 2, 3, 4, 6, 8};
      tsb_entry_id_t id;
      reg_read_check(TSB_LOG_N_TILES, reg_data_t'(N_TILES));
      reg_read_check(reg_addr_t'(8'h04), '0); // Unmapped address.
      foreach (counts[c]) begin
         reg_write(TSB_LOG_N_TILES, reg_data_t'(counts[c]));
         reg_read_check(TSB_LOG_N_TILES, reg_data_t'(counts[c]));
         for (int k = 0; k < 3; k++) send_task(1'b0, id);
         respond(1, 1'b1);
         send_task(1'b0, id); // Refills the hole at entry 1.
         reg_read_check(TSB_ENTRY_VALID, reg_data_t'(valid_bits()));
         ack_all();
      end
   endtask

   task automatic test_fill();
      tsb_entry_id_t id;
      for (int k = 0; k < TSB_SIZE; k++) begin
         send_task(1'b1, id);
         check("s_only_untied", s_only_untied, occupancy() > ONLY_UNTIED_LEVEL);
      end
      @(posedge clk);
      s_wvalid <= 1'b1;
      repeat (3) begin
         @(negedge clk);
         check("s_wready", s_wready, 1'b0);
      end
      @(posedge clk);
      s_wvalid <= 1'b0;
      check("empty", empty, 1'b0);
      reg_read_check(TSB_ENTRY_VALID, reg_data_t'(valid_bits()));
   endtask

   task automatic test_retry_abort();
      tsb_entry_id_t id;
      retry(2, 1'b0, 1'b0);
      retry(5, 1'b1, 1'b0);
      send_task(1'b1, id);
      check("task_enq_tsb_id", task_enq_tsb_id, 5);
   endtask

   task automatic test_responses();
      respond(0, 1'b1);
      respond(2, 1'b1);
      respond(3, 1'b0);
      reg_read_check(TSB_ENTRY_VALID, reg_data_t'(valid_bits()));
      ack_all();
      check("empty", empty, 1'b1);
   endtask

   task automatic test_lvt();
      tsb_entry_id_t id;
      for (int k = 0; k < 4; k++) send_task(1'b1, id);
      repeat (2 * TSB_SIZE + 1) @(posedge clk);
      @(negedge clk);
      check("lvt", lvt, min_ts());
      ack_all();
      repeat (2 * TSB_SIZE + 1) @(posedge clk);
      @(negedge clk);
      check("lvt", lvt, 32'hffff_ffff);
   endtask

   task automatic test_backpressure();
      tsb_entry_id_t id;
      task_t held;
      @(posedge clk);
      task_enq_ready <= 1'b0;
      send_task(1'b1, id);
      held = mtask[id];
      @(posedge clk);
      retry_valid <= 1'b1;
      retry_tsb_id <= id;
      retry_abort <= 1'b0;
      retry_tied <= 1'b1;
      repeat (4) begin
         @(negedge clk);
         check("task_enq_valid", task_enq_valid, 1'b1);
         check("task_enq_data", task_enq_data, held);
         check("task_enq_tsb_id", task_enq_tsb_id, id);
         check("s_wready", s_wready, 1'b0);
         check("retry_ready", retry_ready, 1'b0);
      end
      @(posedge clk);
      retry_valid <= 1'b0;
      task_enq_ready <= 1'b1;
      @(posedge clk);
      @(negedge clk);
      check("task_enq_valid", task_enq_valid, 1'b0);
      @(posedge clk);
      m_resp_ready <= 1'b0;
      respond(id, 1'b1);
      repeat (4) begin
         @(negedge clk);
         check("m_resp_valid", m_resp_valid, 1'b1);
         check("m_tsb_slot", m_tsb_slot, id);
         check("task_resp_ready", task_resp_ready, 1'b0);
      end
      @(posedge clk);
      m_resp_ready <= 1'b1;
      @(posedge clk);
      @(negedge clk);
      check("m_resp_valid", m_resp_valid, 1'b0);
      check("empty", empty, 1'b1);
   endtask

   initial begin
      rstn = 1'b0;
      s_wvalid = 1'b0;
      s_wdata = '0;
      s_tied = 1'b0;
      s_cq_slot = '0;
      s_child_id = '0;
      retry_valid = 1'b0;
      retry_tsb_id = '0;
      retry_abort = 1'b0;
      retry_tied = 1'b0;
      task_enq_ready = 1'b1;
      task_resp_valid = 1'b0;
      task_resp_ack = 1'b0;
      task_resp_tsb_id = '0;
      task_resp_epoch = '0;
      task_resp_tq_slot = '0;
      m_resp_ready = 1'b1;
      reg_wr = '0;
      reg_rd = '0;
      for (int i = 0; i < TSB_SIZE; i++) mvalid[i] = 1'b0;
      repeat (8) @(posedge clk);
      rstn <= 1'b1;
      @(negedge clk);
      check("empty", empty, 1'b1);
      check("lvt", lvt, '0); // Before the first scan ends.
      test_hash_and_regs();
      test_fill();
      test_retry_abort();
      test_responses();
      test_lvt();
      test_backpressure();
      $display("Checks run: %0d, errors: %0d", checks_run, errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== tsb_subsys.f ====
hw/swarm_pkg.sv
hw/tile_hash.sv
hw/tsb_entry_table.sv
hw/tsb_lvt_scan.sv
hw/tsb.sv
hw/tsb_regs.sv
hw/tsb_subsys.sv
testbench/tb_tsb_subsys.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the task send buffer testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -j 0 --top-module tb_tsb_subsys \
   -f tsb_subsys.f -o sim_tsb_subsys
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/sim_tsb_subsys)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "^Test completed successfully$"; then
   exit 0
fi
exit 1
